// ==== Makefile ====
# Verilator build and run for the DES engine testbench

VERILATOR ?= verilator
TOP       ?= des_crypt_tb
FILELIST  ?= des_crypt.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= *** TEST PASSED ***
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
SIM_ARGS  ?= +verilator+error+limit+100

SOURCES := $(wildcard hdl/*.sv hdl/*.svh sim/*.sv)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	@grep -qF -- '$(PASS_MSG)' $(LOG) || (echo "Simulation failed, see $(LOG)" && exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== des_crypt.f ====
+incdir+hdl
hdl/des_pkg.sv
hdl/des_round.sv
hdl/des_pipeline.sv
hdl/des_result_fifo.sv
hdl/des_out_port.sv
hdl/des_crypt_top.sv
sim/des_crypt_properties.sv
sim/des_crypt_tb.sv

// ==== hdl/des_consts.svh ====
`ifndef DES_CONSTS_SVH
`define DES_CONSTS_SVH

// Feistel rounds in the pipeline
`define DES_ROUNDS 16

// Result buffer entries, also the input credits the host owns after reset
`define DES_FIFO_DEPTH 4

// Credits the output port owns after reset
`define DES_OUT_CREDITS 2

`endif

// ==== hdl/des_crypt_top.sv ====
`timescale 1ns/1ns

module des_crypt_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   i_start,
    input  logic                   i_pause,
    input  logic                   i_restart,
    input  des_pkg::des_req_t      i_req,
    input  logic                   i_req_valid,
    input  des_pkg::round_keys_t   i_round_keys,
    input  logic                   i_out_credit,
    output logic                   o_in_credit,
    output des_pkg::des_req_t      o_res,
    output logic                   o_res_valid
);

    des_pkg::des_req_t res_data;
    des_pkg::des_req_t head_data;
    logic              res_write;
    logic              fifo_empty;
    logic              fifo_pop;

    des_pipeline u_pipeline (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_start      (i_start),
        .i_pause      (i_pause),
        .i_restart    (i_restart),
        .i_req        (i_req),
        .i_req_valid  (i_req_valid),
        .i_round_keys (i_round_keys),
        .o_res        (res_data),
        .o_res_write  (res_write)
    );

    des_result_fifo u_fifo (
        .clk      (clk),
        .rst_n    (rst_n),
        .i_flush  (i_restart),
        .i_write  (res_write),
        .i_data   (res_data),
        .i_pop    (fifo_pop),
        .o_data   (head_data),
        .o_empty  (fifo_empty),
        .o_credit (o_in_credit)
    );

    des_out_port u_out_port (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_empty      (fifo_empty),
        .i_data       (head_data),
        .i_out_credit (i_out_credit),
        .o_pop        (fifo_pop),
        .o_res        (o_res),
        .o_res_valid  (o_res_valid)
    );

endmodule

// ==== hdl/des_out_port.sv ====
`timescale 1ns/1ns

`include "des_consts.svh"

module des_out_port (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                i_empty,
    input  des_pkg::des_req_t   i_data,
    input  logic                i_out_credit,
    output logic                o_pop,
    output des_pkg::des_req_t   o_res,
    output logic                o_res_valid
);

    localparam int CW = $clog2(`DES_OUT_CREDITS) + 1;

    logic [CW-1:0] credit_cnt;

    // Sink must have room for the result
    assign o_pop = (credit_cnt != '0) && !i_empty;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            credit_cnt  <= CW'(`DES_OUT_CREDITS);
            o_res_valid <= 1'b0;
        end else begin
            credit_cnt  <= credit_cnt + CW'(i_out_credit) - CW'(o_pop);
            o_res_valid <= o_pop;                       // Single cycle per result
        end
    end

    always_ff @(posedge clk) begin
        if (o_pop) begin
            o_res <= i_data;
        end
    end

endmodule

// ==== hdl/des_pipeline.sv ====
`timescale 1ns/1ns

`include "des_consts.svh"

module des_pipeline (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   i_start,
    input  logic                   i_pause,
    input  logic                   i_restart,
    input  des_pkg::des_req_t      i_req,
    input  logic                   i_req_valid,
    input  des_pkg::round_keys_t   i_round_keys,
    output des_pkg::des_req_t      o_res,
    output logic                   o_res_write
);

    localparam int IP_TAB [64] = '{
        58, 50, 42, 34, 26, 18, 10,  2, 60, 52, 44, 36, 28, 20, 12,  4,
        62, 54, 46, 38, 30, 22, 14,  6, 64, 56, 48, 40, 32, 24, 16,  8,
        57, 49, 41, 33, 25, 17,  9,  1, 59, 51, 43, 35, 27, 19, 11,  3,
        61, 53, 45, 37, 29, 21, 13,  5, 63, 55, 47, 39, 31, 23, 15,  7
    };

    localparam int FP_TAB [64] = '{
        40,  8, 48, 16, 56, 24, 64, 32, 39,  7, 47, 15, 55, 23, 63, 31,
        38,  6, 46, 14, 54, 22, 62, 30, 37,  5, 45, 13, 53, 21, 61, 29,
        36,  4, 44, 12, 52, 20, 60, 28, 35,  3, 43, 11, 51, 19, 59, 27,
        34,  2, 42, 10, 50, 18, 58, 26, 33,  1, 41,  9, 49, 17, 57, 25
    };

    localparam int KW = $bits(des_pkg::subkey_t);

    des_pkg::run_state_e state;
    des_pkg::run_state_e next_state;
    logic                enable;

    des_pkg::stage_t     stages [0:`DES_ROUNDS];
    des_pkg::block_t     ip_block;
    des_pkg::block_t     fp_block;
    des_pkg::block_t     last_swap;

    logic                s0_valid;
    des_pkg::block_t     s0_block;
    logic                s0_decrypt;
    logic                out_valid;
    des_pkg::des_req_t   out_reg;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= des_pkg::st_idle;
        end else if (i_restart) begin
            state <= des_pkg::st_idle;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            des_pkg::st_idle:    if (i_start) next_state = des_pkg::st_running;
            des_pkg::st_running: if (i_pause) next_state = des_pkg::st_paused;
            des_pkg::st_paused:  if (!i_pause) next_state = des_pkg::st_running;
            default:             next_state = des_pkg::st_idle;
        endcase
    end

    assign enable = (state == des_pkg::st_running);     // Every stage moves together

    // Initial permutation feeds the first register
    always_comb begin
        for (int k = 0; k < 64; k++) begin
            ip_block[63-k] = i_req.data[64-IP_TAB[k]];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n || i_restart) begin
            s0_valid <= 1'b0;
        end else if (enable) begin
            s0_valid <= i_req_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (enable) begin
            s0_block   <= ip_block;
            s0_decrypt <= i_req.decrypt;
        end
    end

    assign stages[0] = '{valid: s0_valid, decrypt: s0_decrypt,
                         left: s0_block[63:32], right: s0_block[31:0]};

    for (genvar k = 1; k <= `DES_ROUNDS; k++) begin : g_round
        des_pkg::subkey_t key;

        // Decrypt walks the schedule backwards
        assign key = stages[k-1].decrypt ? i_round_keys[KW*(k-1) +: KW]
                                         : i_round_keys[KW*(`DES_ROUNDS-k) +: KW];

        des_round u_round (
            .clk      (clk),
            .rst_n    (rst_n),
            .i_enable (enable),
            .i_flush  (i_restart),
            .i_stage  (stages[k-1]),
            .i_key    (key),
            .o_stage  (stages[k])
        );
    end

    // Last swap is undone before the final permutation
    assign last_swap = {stages[`DES_ROUNDS].right, stages[`DES_ROUNDS].left};

    always_comb begin
        for (int k = 0; k < 64; k++) begin
            fp_block[63-k] = last_swap[64-FP_TAB[k]];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n || i_restart) begin
            out_valid <= 1'b0;
        end else if (enable) begin
            out_valid <= stages[`DES_ROUNDS].valid;
        end
    end

    always_ff @(posedge clk) begin
        if (enable) begin
            out_reg <= '{data: fp_block, decrypt: stages[`DES_ROUNDS].decrypt};
        end
    end

    assign o_res       = out_reg;
    assign o_res_write = out_valid & enable;            // Held result waits out a pause

endmodule

// ==== hdl/des_pkg.sv ====
`include "des_consts.svh"

package des_pkg;

    typedef logic [63:0] block_t;     // DES bit 1 sits at bit 63
    typedef logic [31:0] half_t;
    typedef logic [47:0] subkey_t;

    // Round 1 subkey in the top 48 bits
    typedef logic [`DES_ROUNDS*48-1:0] round_keys_t;

    typedef struct packed {
        block_t data;
        logic   decrypt;
    } des_req_t;

    // What moves from one round register to the next
    typedef struct packed {
        logic   valid;
        logic   decrypt;
        half_t  left;
        half_t  right;
    } stage_t;

    typedef enum logic [1:0] {
        st_idle,
        st_running,
        st_paused
    } run_state_e;

endpackage

// ==== hdl/des_result_fifo.sv ====
`timescale 1ns/1ns

`include "des_consts.svh"

module des_result_fifo (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                i_flush,
    input  logic                i_write,
    input  des_pkg::des_req_t   i_data,
    input  logic                i_pop,
    output des_pkg::des_req_t   o_data,
    output logic                o_empty,
    output logic                o_credit
);

    localparam int AW = $clog2(`DES_FIFO_DEPTH);

    des_pkg::des_req_t mem [`DES_FIFO_DEPTH];
    logic [AW-1:0]     wr_ptr;
    logic [AW-1:0]     rd_ptr;
    logic [AW:0]       count;

    always_ff @(posedge clk) begin
        if (!rst_n || i_flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (i_write) wr_ptr <= wr_ptr + 1'b1;        // Depth is a power of two
            if (i_pop) rd_ptr <= rd_ptr + 1'b1;
            count <= count + (AW+1)'(i_write) - (AW+1)'(i_pop);
        end
    end

    always_ff @(posedge clk) begin
        if (i_write) begin
            mem[wr_ptr] <= i_data;
        end
    end

    // One input credit back per freed entry
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            o_credit <= 1'b0;
        end else begin
            o_credit <= i_pop;
        end
    end

    assign o_data  = mem[rd_ptr];
    assign o_empty = (count == '0) | i_flush;           // Nothing leaves while clearing

endmodule

// ==== hdl/des_round.sv ====
`timescale 1ns/1ns

module des_round (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               i_enable,
    input  logic               i_flush,
    input  des_pkg::stage_t    i_stage,
    input  des_pkg::subkey_t   i_key,
    output des_pkg::stage_t    o_stage
);

    // Expansion E, entry k gives the source bit of output bit k+1
    localparam int E_TAB [48] = '{
        32,  1,  2,  3,  4,  5,
         4,  5,  6,  7,  8,  9,
         8,  9, 10, 11, 12, 13,
        12, 13, 14, 15, 16, 17,
        16, 17, 18, 19, 20, 21,
        20, 21, 22, 23, 24, 25,
        24, 25, 26, 27, 28, 29,
        28, 29, 30, 31, 32,  1
    };

    localparam int P_TAB [32] = '{
        16,  7, 20, 21, 29, 12, 28, 17,
         1, 15, 23, 26,  5, 18, 31, 10,
         2,  8, 24, 14, 32, 27,  3,  9,
        19, 13, 30,  6, 22, 11,  4, 25
    };

    // S1 to S8, four rows of sixteen nibbles each, row 0 first
    localparam logic [0:7][255:0] SBOX = '{
        256'hE4D12FB83A6C5907_0F74E2D1A6CB9538_41E8D62BFC973A50_FC8249175B3EA06D,
        256'hF18E6B34972DC05A_3D47F28EC01A69B5_0E7BA4D158C6932F_D8A13F42B67C05E9,
        256'hA09E63F51DC7B428_D709346A285ECBF1_D6498F30B12C5AE7_1AD069874FE3B52C,
        256'h7DE3069A1285BC4F_D8B56F03472C1AE9_A690CB7DF13E5284_3F06A1D8945BC72E,
        256'h2C417AB6853FD0E9_EB2C47D150FA3986_421BAD78F9C5630E_B8C71E2D6F09A453,
        256'hC1AF92680D34E75B_AF427C9561DE0B38_9EF528C3704A1DB6_432C95FABE17608D,
        256'h4B2EF08D3C975A61_D0B7491AE35C2F86_14BDC37EAF680592_6BD814A7950FE23C,
        256'hD2846FB1A93E50C7_1FD8A374C56B0E92_7B419CE206ADF358_21E74A8DFC90356B
    };

    des_pkg::subkey_t expanded;
    des_pkg::subkey_t mixed;
    des_pkg::half_t   sbox_out;
    des_pkg::half_t   f_out;

    logic             r_valid;
    logic             r_decrypt;
    des_pkg::half_t   r_left;
    des_pkg::half_t   r_right;

    always_comb begin
        for (int k = 0; k < 48; k++) begin
            expanded[47-k] = i_stage.right[32-E_TAB[k]];
        end
    end

    assign mixed = expanded ^ i_key;

    always_comb begin
        logic [5:0] chunk;
        int         sel;
        chunk = '0;
        sel = 0;
        for (int s = 0; s < 8; s++) begin
            chunk = mixed[47-6*s -: 6];
            sel = {chunk[5], chunk[0], chunk[4:1]};     // Outer bits pick the row
            sbox_out[31-4*s -: 4] = SBOX[s][255-4*sel -: 4];
        end
    end

    always_comb begin
        for (int k = 0; k < 32; k++) begin
            f_out[31-k] = sbox_out[32-P_TAB[k]];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            r_valid <= 1'b0;
        end else if (i_flush) begin
            r_valid <= 1'b0;                            // Drop the block in this stage
        end else if (i_enable) begin
            r_valid <= i_stage.valid;
        end
    end

    // Halves swap on every round
    always_ff @(posedge clk) begin
        if (i_enable) begin
            r_decrypt <= i_stage.decrypt;
            r_left    <= i_stage.right;
            r_right   <= i_stage.left ^ f_out;
        end
    end

    assign o_stage = '{valid: r_valid, decrypt: r_decrypt, left: r_left, right: r_right};

endmodule

// ==== sim/des_crypt_properties.sv ====
`timescale 1ns/1ns

`include "des_consts.svh"

module des_crypt_properties (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                i_req_valid,
    input  des_pkg::run_state_e                 state,
    input  logic                                fifo_write,
    input  logic [$clog2(`DES_FIFO_DEPTH):0]    fifo_count,
    input  logic                                i_out_credit,
    input  logic                                o_res_valid,
    input  logic                                o_in_credit
);

    int fail_count = 0;     // Read by the testbench at the end
    int held;               // Credits the sink has granted and not yet seen used

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            held <= `DES_OUT_CREDITS;
        end else begin
            held <= held + int'(i_out_credit) - int'(o_res_valid);
        end
    end

    // Host sends only while the pipeline runs
    a_req_running: assert property (@(posedge clk) disable iff (!rst_n)
        i_req_valid |-> state == des_pkg::st_running)
        else begin
            $error("request accepted while the pipeline is not running");
            fail_count++;
        end

    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        fifo_write |-> fifo_count < `DES_FIFO_DEPTH)
        else begin
            $error("result buffer written while full");
            fail_count++;
        end

    // Each result uses up a credit the sink handed out earlier
    a_out_credit: assert property (@(posedge clk) disable iff (!rst_n)
        o_res_valid |-> held > 0)
        else begin
            $error("result presented without an output credit");
            fail_count++;
        end

    a_credit_pairs: assert property (@(posedge clk) disable iff (!rst_n)
        o_in_credit == o_res_valid)
        else begin
            $error("input credit and result valid pulses differ");
            fail_count++;
        end

endmodule

bind des_crypt_top des_crypt_properties u_props (
    .clk          (clk),
    .rst_n        (rst_n),
    .i_req_valid  (i_req_valid),
    .state        (u_pipeline.state),
    .fifo_write   (u_fifo.i_write),
    .fifo_count   (u_fifo.count),
    .i_out_credit (i_out_credit),
    .o_res_valid  (o_res_valid),
    .o_in_credit  (o_in_credit)
);

// ==== sim/des_crypt_tb.sv ====
`timescale 1ns/1ns

`include "des_consts.svh"

module des_crypt_tb;

    localparam int TIMEOUT = 2000;

    logic                  clk;
    logic                  rst_n;
    logic                  i_start;
    logic                  i_pause;
    logic                  i_restart;
    des_pkg::des_req_t     i_req;
    logic                  i_req_valid;
    des_pkg::round_keys_t  i_round_keys;
    logic                  i_out_credit;
    logic                  o_in_credit;
    des_pkg::des_req_t     o_res;
    logic                  o_res_valid;

    logic [31:0]           rng;
    logic [31:0]           sink_rng;
    des_pkg::run_state_e   run_model;       // DUT state in the current cycle
    int                    host_credits;
    int                    sink_owed;       // Results the sink has not paid back yet
    int                    granted;
    int                    results;
    bit                    withhold;
    bit                    pause_mode;
    int                    err_cnt;
    int                    start_err;
    int                    tests_run;
    int                    tests_failed;
    string                 test_name;

    des_pkg::des_req_t     exp_q [$];
    des_pkg::block_t       cipher_of [des_pkg::block_t];
    des_pkg::block_t       plain_of [des_pkg::block_t];
    des_pkg::block_t       known_ct [$];

    des_crypt_top DUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_start      (i_start),
        .i_pause      (i_pause),
        .i_restart    (i_restart),
        .i_req        (i_req),
        .i_req_valid  (i_req_valid),
        .i_round_keys (i_round_keys),
        .i_out_credit (i_out_credit),
        .o_in_credit  (o_in_credit),
        .o_res        (o_res),
        .o_res_valid  (o_res_valid)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng = xorshift(rng);
        return rng;
    endfunction

    function automatic des_pkg::block_t rand_block();
        des_pkg::block_t b;
        b[63:32] = next_rand();
        b[31:0]  = next_rand();
        return b;
    endfunction

    task automatic check_block(input des_pkg::block_t expected, input des_pkg::block_t actual);
        if (actual !== expected) begin
            $display("FAIL %s block expected %h actual %h", test_name, expected, actual);
            err_cnt++;
        end
    endtask

    task automatic check_flag(input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("FAIL %s flag expected %0b actual %0b", test_name, expected, actual);
            err_cnt++;
        end
    endtask

    // A new plaintext and ciphertext pair must not clash with earlier ones
    task automatic record_pair(input des_pkg::block_t pt, input des_pkg::block_t ct);
        if (plain_of.exists(ct) || cipher_of.exists(pt)) begin
            $display("%s: plaintext %h and ciphertext %h clash with an earlier pair",
                     test_name, pt, ct);
            err_cnt++;
        end else begin
            cipher_of[pt] = ct;
            plain_of[ct]  = pt;
            known_ct.push_back(ct);
        end
    endtask

    task automatic score_result(input des_pkg::des_req_t res);
        des_pkg::des_req_t exp;
        exp = exp_q.pop_front();
        check_flag(exp.decrypt, res.decrypt);
        if (!exp.decrypt) begin
            if (cipher_of.exists(exp.data)) check_block(cipher_of[exp.data], res.data);
            else record_pair(exp.data, res.data);
        end else begin
            if (plain_of.exists(exp.data)) check_block(plain_of[exp.data], res.data);
            else record_pair(res.data, exp.data);   // Decrypt of C gives the plaintext of C
        end
    endtask

    // Results and returned input credits, sampled on the edge
    always @(posedge clk) begin
        if (rst_n) begin
            if (o_in_credit) host_credits++;
            if (o_res_valid) begin
                results++;
                sink_owed++;
                if (results > `DES_OUT_CREDITS + granted) begin
                    $display("%s: %0d results seen but only %0d output credits granted",
                             test_name, results, `DES_OUT_CREDITS + granted);
                    err_cnt++;
                end
                if (exp_q.size() == 0) begin
                    $display("%s: result %h arrived with no request outstanding",
                             test_name, o_res.data);
                    err_cnt++;
                end else begin
                    score_result(o_res);
                end
            end
        end
    end

    // Sink pays back one credit per result, late when withholding
    always begin
        @(posedge clk);
        #2;
        i_out_credit = 1'b0;
        sink_rng = xorshift(sink_rng);
        if (sink_owed > 0 && (!withhold || sink_rng[1:0] == 2'b00)) begin
            i_out_credit = 1'b1;
            sink_owed--;
            granted++;
        end
    end

    task automatic tick();
        // State the DUT enters at the coming edge
        if (i_restart) begin
            run_model = des_pkg::st_idle;
        end else begin
            case (run_model)
                des_pkg::st_idle:    if (i_start) run_model = des_pkg::st_running;
                des_pkg::st_running: if (i_pause) run_model = des_pkg::st_paused;
                des_pkg::st_paused:  if (!i_pause) run_model = des_pkg::st_running;
                default:             run_model = des_pkg::st_idle;
            endcase
        end
        @(posedge clk);
        #2;
        i_req_valid = 1'b0;
        if (pause_mode && next_rand() % 32'd5 == 0) i_pause = ~i_pause;
    endtask

    task automatic send_req(input des_pkg::des_req_t req);
        int waited;
        waited = 0;
        while ((host_credits == 0 || run_model != des_pkg::st_running) && waited < TIMEOUT) begin
            tick();
            waited++;
        end
        if (host_credits == 0 || run_model != des_pkg::st_running) begin
            $display("%s: timed out waiting for an input credit", test_name);
            err_cnt++;
        end else begin
            i_req       = req;
            i_req_valid = 1'b1;
            host_credits--;
            exp_q.push_back(req);
            tick();
        end
    endtask

    task automatic wait_results();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < TIMEOUT) begin
            tick();
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("%s: timed out with %0d results missing", test_name, exp_q.size());
            err_cnt++;
            exp_q.delete();
        end else if (host_credits != `DES_FIFO_DEPTH) begin
            $display("%s: host holds %0d input credits after draining", test_name, host_credits);
            err_cnt++;
        end
    endtask

    task automatic start_engine();
        int waited;
        waited = 0;
        i_start = 1'b1;
        tick();
        i_start = 1'b0;
        while (run_model != des_pkg::st_running && waited < TIMEOUT) begin
            tick();
            waited++;
        end
        if (run_model != des_pkg::st_running) begin
            $display("%s: pipeline did not reach the running state", test_name);
            err_cnt++;
        end
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        start_err = err_cnt;
    endtask

    task automatic end_test();
        tests_run++;
        if (err_cnt == start_err) begin
            $display("test %s: ok", test_name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", test_name, err_cnt - start_err);
        end
    endtask

    task automatic run_round_trip(input int n);
        des_pkg::block_t   pt [$];
        des_pkg::des_req_t req;
        for (int i = 0; i < n; i++) begin
            pt.push_back(rand_block());
            req = '{data: pt[i], decrypt: 1'b0};
            send_req(req);
        end
        wait_results();
        for (int i = 0; i < n; i++) begin
            if (cipher_of.exists(pt[i])) begin
                req = '{data: cipher_of[pt[i]], decrypt: 1'b1};
                send_req(req);
            end else begin
                $display("%s: no ciphertext recorded for plaintext %h", test_name, pt[i]);
                err_cnt++;
            end
        end
        wait_results();
    endtask

    // Fresh encrypts mixed with decrypts of known ciphertexts
    task automatic send_mixed(input int n);
        des_pkg::des_req_t req;
        logic [31:0]       r;
        int                idx;
        for (int i = 0; i < n; i++) begin
            r = next_rand();
            if (r[0] && known_ct.size() > 0) begin
                idx = int'(r[15:8]) % known_ct.size();
                req = '{data: known_ct[idx], decrypt: 1'b1};
            end else begin
                req = '{data: rand_block(), decrypt: 1'b0};
            end
            send_req(req);
        end
    endtask

    task automatic run_determinism();
        des_pkg::des_req_t req;
        des_pkg::block_t   fresh;
        for (int i = 0; i < 4; i++) begin
            req = '{data: plain_of[known_ct[i]], decrypt: 1'b0};
            send_req(req);
        end
        fresh = rand_block();
        req = '{data: fresh, decrypt: 1'b0};
        send_req(req);
        send_req(req);                  // Second copy is checked against the first
        wait_results();
    endtask

    task automatic run_restart();
        des_pkg::des_req_t req;
        for (int i = 0; i < 3; i++) begin
            req = '{data: rand_block(), decrypt: 1'b0};
            send_req(req);
        end
        repeat (5) tick();              // Blocks still inside the rounds
        i_restart = 1'b1;
        tick();
        i_restart = 1'b0;
        exp_q.delete();
        host_credits = `DES_FIFO_DEPTH;
        repeat (40) tick();             // Any result here is flagged by the monitor
        start_engine();
        run_round_trip(6);
    endtask

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        i_start      = 1'b0;
        i_pause      = 1'b0;
        i_restart    = 1'b0;
        i_req        = '0;
        i_req_valid  = 1'b0;
        i_round_keys = '0;
        i_out_credit = 1'b0;
        rng          = 32'd68805;
        sink_rng     = xorshift(32'd68805 ^ 32'h5a5a_5a5a);
        run_model    = des_pkg::st_idle;
        host_credits = `DES_FIFO_DEPTH;
        sink_owed    = 0;
        granted      = 0;
        results      = 0;
        withhold     = 1'b0;
        pause_mode   = 1'b0;
        err_cnt      = 0;
        start_err    = 0;
        tests_run    = 0;
        tests_failed = 0;
        test_name    = "reset";
        for (int k = 0; k < `DES_ROUNDS * 48 / 32; k++) begin
            i_round_keys[32*k +: 32] = next_rand();
        end

        repeat (10) @(posedge clk);
        #2;
        rst_n = 1'b1;
        start_engine();

        begin_test("round_trip");
        run_round_trip(12);
        end_test();

        begin_test("order_flag");
        send_mixed(16);
        wait_results();
        end_test();

        begin_test("determinism");
        run_determinism();
        end_test();

        begin_test("back_pressure");
        withhold = 1'b1;
        send_mixed(20);
        wait_results();
        withhold = 1'b0;
        end_test();

        begin_test("pause");
        pause_mode = 1'b1;
        send_mixed(20);
        wait_results();
        pause_mode = 1'b0;
        i_pause = 1'b0;
        tick();
        tick();
        end_test();

        begin_test("restart");
        run_restart();
        end_test();

        $display("tests run %0d, tests failed %0d, errors %0d, assertion failures %0d",
                 tests_run, tests_failed, err_cnt, DUT.u_props.fail_count);
        if (err_cnt == 0 && DUT.u_props.fail_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule
